// File: all.f
+incdir+hdl
hdl/inq_pkg.sv
hdl/inq_wl_ring.sv
hdl/inq_rf16x128.sv
hdl/inq_ctl.sv
hdl/inq_out_stage.sv
hdl/inq_top.sv
sim/inq_tb.sv

// File: hdl/inq_ctl.sv
////////////////////////////////////////
// occupancy control, strobes to the rf
// are combinational from enq/deq/flush
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_ctl import inq_pkg::*; (
  input  wire logic rclk,
  input  wire logic reset_l,  // sync, active high
  input  wire logic enq,
  input  wire logic deq,
  input  wire logic flush,
  output logic      wr_en,    // to rf, flopped there
  output logic      read_en,  // to rf, flopped there
  output logic      wr_adv,   // write ring step
  output logic      rd_adv,   // read ring step
  output logic      ring_clr, // both rings
  output logic      out_load, // one cycle after an accepted pop
  output inq_cnt_t  count,
  output logic      full,
  output logic      empty,
  output logic      ovf       // sticky, survives flush
);

  localparam inq_cnt_t CNT_MAX = inq_cnt_t'(`INQ_DEPTH);

  inq_state_t state;
  inq_state_t state_nxt;
  inq_cnt_t   cnt_nxt;
  logic       push_ok;
  logic       pop_ok;

  ////////////////////////////////////////
  // acceptance
  ////////////////////////////////////////
  // full blocks the push even with a pop in the same cycle
  assign push_ok = enq && !full && !flush;
  assign pop_ok  = deq && !empty && !flush;

  assign wr_en    = push_ok;
  assign wr_adv   = push_ok;
  assign read_en  = pop_ok;
  assign rd_adv   = pop_ok;
  assign ring_clr = flush;

  // status from the state
  assign full  = (state == IQ_FULL);
  assign empty = (state == IQ_EMPTY);

  // next count and state
  always_comb begin
    cnt_nxt = count + inq_cnt_t'(push_ok) - inq_cnt_t'(pop_ok);
    if (flush)
      cnt_nxt = '0;
    if (cnt_nxt == '0)
      state_nxt = IQ_EMPTY;
    else if (cnt_nxt == CNT_MAX)
      state_nxt = IQ_FULL;
    else
      state_nxt = IQ_PART;
  end

  ////////////////////////////////////////
  // state flops
  ////////////////////////////////////////
  always_ff @(posedge rclk) begin
    if (reset_l) begin
      state    <= IQ_EMPTY;
      count    <= '0;
      ovf      <= 1'b0;
      out_load <= 1'b0;
    end else begin
      state    <= state_nxt;
      count    <= cnt_nxt;
      out_load <= pop_ok;         // in-flight pop not cancelled by flush
      if (enq && full && !flush)
        ovf <= 1'b1;              // dropped push
    end
  end

endmodule

`default_nettype wire

// File: hdl/inq_out_stage.sv
////////////////////////////////////////
// popped packet register, even parity
// per word, no back-pressure
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_out_stage import inq_pkg::*; (
  input  wire logic      rclk,
  input  wire logic      reset_l, // sync, active high
  input  wire logic      load,
  input  wire inq_data_t rdata,
  output inq_data_t      pkt,     // held until the next load
  output inq_par_t       pkt_par, // bit 0 is the low word
  output logic           pkt_vld  // one cycle per load
);

  inq_par_t par_nxt;

  // xor of each word, makes word plus bit even
  always_comb begin
    for (int w = 0; w < $bits(inq_par_t); w++) begin
      par_nxt[w] = ^rdata[w*`INQ_PAR_WORD +: `INQ_PAR_WORD];
    end
  end

  always_ff @(posedge rclk) begin
    if (reset_l) begin
      pkt     <= '0;
      pkt_par <= '0;
      pkt_vld <= 1'b0;
    end else begin
      pkt_vld <= load;
      if (load) begin
        pkt     <= rdata;
        pkt_par <= par_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/inq_pkg.sv
////////////////////////////////////////
// shared types for the inbound queue
////////////////////////////////////////

`default_nettype none

package inq_pkg;

  `include "inq_settings.svh"

  typedef logic [`INQ_WIDTH-1:0]                 inq_data_t; // one packet
  typedef logic [`INQ_DEPTH-1:0]                 inq_wl_t;   // one-hot wordline
  typedef logic [`INQ_PTR_W-1:0]                 inq_ptr_t;  // entry index
  typedef logic [`INQ_CNT_W-1:0]                 inq_cnt_t;  // 0..depth
  typedef logic [`INQ_WIDTH/`INQ_PAR_WORD-1:0]   inq_par_t;  // one bit per word

  // occupancy states
  typedef enum logic [1:0] {
    IQ_EMPTY,
    IQ_PART,
    IQ_FULL
  } inq_state_t;

endpackage

`default_nettype wire

// File: hdl/inq_rf16x128.sv
////////////////////////////////////////
// 16x128 1r1w regfile, inputs flopped,
// write lands one edge after sampling
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_rf16x128 import inq_pkg::*; (
  input  wire logic      rclk,
  input  wire logic      reset_l,    // sync, active high
  input  wire inq_data_t din,
  input  wire inq_wl_t   wr_wl,      // one-hot, zero means no write
  input  wire inq_wl_t   rd_wl,      // one-hot
  input  wire logic      wr_en,
  input  wire logic      read_en,
  input  wire logic      rst_tri_en, // test gate
  output inq_data_t      dout
);

  inq_data_t ary [`INQ_DEPTH]; // storage, no reset

  inq_data_t wrdata_d1;
  inq_wl_t   wr_wl_d1;
  inq_wl_t   rd_wl_d1;
  logic      wr_en_d1;
  logic      ren_d1;
  logic      tri_d1;
  inq_ptr_t  wrptr_d1;
  inq_ptr_t  rdptr_d1;

  // one-hot to index, anything else maps to entry 0
  function automatic inq_ptr_t wl_to_ptr(input inq_wl_t wl);
    inq_ptr_t p;
    p = '0;
    case (wl)
      16'b0000_0000_0000_0001: p = 4'd0;
      16'b0000_0000_0000_0010: p = 4'd1;
      16'b0000_0000_0000_0100: p = 4'd2;
      16'b0000_0000_0000_1000: p = 4'd3;
      16'b0000_0000_0001_0000: p = 4'd4;
      16'b0000_0000_0010_0000: p = 4'd5;
      16'b0000_0000_0100_0000: p = 4'd6;
      16'b0000_0000_1000_0000: p = 4'd7;
      16'b0000_0001_0000_0000: p = 4'd8;
      16'b0000_0010_0000_0000: p = 4'd9;
      16'b0000_0100_0000_0000: p = 4'd10;
      16'b0000_1000_0000_0000: p = 4'd11;
      16'b0001_0000_0000_0000: p = 4'd12;
      16'b0010_0000_0000_0000: p = 4'd13;
      16'b0100_0000_0000_0000: p = 4'd14;
      16'b1000_0000_0000_0000: p = 4'd15;
      default:                 p = 4'd0;
    endcase
    return p;
  endfunction

  ////////////////////////////////////////
  // input flops
  ////////////////////////////////////////
  always_ff @(posedge rclk) begin
    wrdata_d1 <= din;
    wr_wl_d1  <= wr_wl;
    rd_wl_d1  <= rd_wl;
    if (reset_l) begin
      wr_en_d1 <= 1'b0;
      ren_d1   <= 1'b0;
      tri_d1   <= 1'b0;
    end else begin
      wr_en_d1 <= wr_en;
      ren_d1   <= read_en;
      tri_d1   <= rst_tri_en; // gate follows the access it qualifies
    end
  end

  assign wrptr_d1 = wl_to_ptr(wr_wl_d1);
  assign rdptr_d1 = wl_to_ptr(rd_wl_d1);

  ////////////////////////////////////////
  // write, one edge after the flops
  ////////////////////////////////////////
  always_ff @(posedge rclk) begin
    if (wr_en_d1 && !tri_d1 && (wr_wl_d1 != '0))
      ary[wrptr_d1] <= wrdata_d1;
  end

  // read path, old contents on a same-entry write
  always_comb begin
    if (!ren_d1)
      dout = '0;                     // idle and after reset
    else if (tri_d1)
      dout = '1;                     // test gate forces ones
    else
      dout = ary[rdptr_d1];
  end

endmodule

`default_nettype wire

// File: hdl/inq_settings.svh
////////////////////////////////////////
// queue sizing, depth must stay 16 while
// the wordline decode is a fixed case
////////////////////////////////////////

`ifndef INQ_SETTINGS_SVH
`define INQ_SETTINGS_SVH

// entries in the register file
`define INQ_DEPTH    16
// packet width in bits
`define INQ_WIDTH    128
// encoded entry index
`define INQ_PTR_W    4
// occupancy 0..16 needs one extra bit
`define INQ_CNT_W    5
// bits per parity bit
`define INQ_PAR_WORD 32

`endif

// File: hdl/inq_top.sv
////////////////////////////////////////
// inbound queue, pkt two edges after deq
// consumer must take pkt on pkt_vld
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_top import inq_pkg::*; (
  input  wire logic      rclk,
  input  wire logic      reset_l,    // sync, active high
  input  wire logic      enq,
  input  wire inq_data_t enq_data,
  input  wire logic      deq,
  input  wire logic      flush,
  input  wire logic      rst_tri_en, // test gate, ones out
  output inq_data_t      pkt,
  output inq_par_t       pkt_par,
  output logic           pkt_vld,
  output inq_cnt_t       count,
  output logic           full,
  output logic           empty,
  output logic           ovf
);

  logic      wr_en;
  logic      read_en;
  logic      wr_adv;
  logic      rd_adv;
  logic      ring_clr;
  logic      out_load;
  inq_wl_t   wr_wl;
  inq_wl_t   rd_wl;
  inq_data_t rf_dout;

  ////////////////////////////////////////
  // control and rings
  ////////////////////////////////////////
  inq_ctl ctl (
    .rclk     (rclk),
    .reset_l  (reset_l),
    .enq      (enq),
    .deq      (deq),
    .flush    (flush),
    .wr_en    (wr_en),
    .read_en  (read_en),
    .wr_adv   (wr_adv),
    .rd_adv   (rd_adv),
    .ring_clr (ring_clr),
    .out_load (out_load),
    .count    (count),
    .full     (full),
    .empty    (empty),
    .ovf      (ovf)
  );

  inq_wl_ring wr_ring (
    .rclk    (rclk),
    .reset_l (reset_l),
    .adv     (wr_adv),
    .clr     (ring_clr),
    .wl      (wr_wl)
  );

  inq_wl_ring rd_ring (
    .rclk    (rclk),
    .reset_l (reset_l),
    .adv     (rd_adv),
    .clr     (ring_clr),
    .wl      (rd_wl)
  );

  ////////////////////////////////////////
  // storage and output
  ////////////////////////////////////////
  inq_rf16x128 rf (
    .rclk       (rclk),
    .reset_l    (reset_l),
    .din        (enq_data),   // straight from the producer
    .wr_wl      (wr_wl),
    .rd_wl      (rd_wl),
    .wr_en      (wr_en),
    .read_en    (read_en),
    .rst_tri_en (rst_tri_en),
    .dout       (rf_dout)
  );

  inq_out_stage out_stage (
    .rclk    (rclk),
    .reset_l (reset_l),
    .load    (out_load),
    .rdata   (rf_dout),
    .pkt     (pkt),
    .pkt_par (pkt_par),
    .pkt_vld (pkt_vld)
  );

endmodule

`default_nettype wire

// File: hdl/inq_wl_ring.sv
////////////////////////////////////////
// one-hot wordline ring, clr beats adv
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_wl_ring import inq_pkg::*; (
  input  wire logic rclk,
  input  wire logic reset_l, // sync, active high
  input  wire logic adv,     // step to next entry
  input  wire logic clr,     // back to entry 0
  output inq_wl_t   wl
);

  localparam inq_wl_t WL_FIRST = inq_wl_t'(1); // entry 0

  always_ff @(posedge rclk) begin
    if (reset_l) begin
      wl <= WL_FIRST;
    end else if (clr) begin
      wl <= WL_FIRST;
    end else if (adv) begin
      // rotate up, top entry wraps to bit 0
      wl <= {wl[`INQ_DEPTH-2:0], wl[`INQ_DEPTH-1]};
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the inbound queue testbench with verilator and run it
# exit status is nonzero when the build fails or the run stops on $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module inq_tb \
  --Mdir obj_dir -o inq_sim \
  && ./obj_dir/inq_sim \
  || exit 1

// File: sim/inq_tb.sv
////////////////////////////////////////
// directed tests for inq_top
// inputs driven and outputs checked on
// the falling edge
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "inq_settings.svh"

module inq_tb import inq_pkg::*; ();

  // tests need about 140 cycles with wide margin
  localparam int MAX_CYCLES = 2000;

  logic      rclk;
  logic      reset_l;
  logic      enq;
  inq_data_t enq_data;
  logic      deq;
  logic      flush;
  logic      rst_tri_en;
  inq_data_t pkt;
  inq_par_t  pkt_par;
  logic      pkt_vld;
  inq_cnt_t  count;
  logic      full;
  logic      empty;
  logic      ovf;

  // software queue model
  inq_data_t   mdl_q[$];
  logic        mdl_ovf;
  logic        stg_vld;       // output due at the next edge
  inq_data_t   stg_pkt;
  logic        exp_vld;
  inq_data_t   exp_pkt;       // held like pkt
  int          cycles = 0;
  string       cur_test;

  inq_top uut (
    .rclk       (rclk),
    .reset_l    (reset_l),
    .enq        (enq),
    .enq_data   (enq_data),
    .deq        (deq),
    .flush      (flush),
    .rst_tri_en (rst_tri_en),
    .pkt        (pkt),
    .pkt_par    (pkt_par),
    .pkt_vld    (pkt_vld),
    .count      (count),
    .full       (full),
    .empty      (empty),
    .ovf        (ovf)
  );

  initial begin
    rclk = 1'b0;
    forever #5 rclk = ~rclk; // 10 ns
  end

  // run limit
  always @(posedge rclk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no end of tests after %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "run limit reached");
    end
  end

  ////////////////////////////////////////
  // model helpers and checks
  ////////////////////////////////////////
  // bit set when its word has an odd count of ones
  // bit 0 covers the low word
  function automatic inq_par_t word_par(input inq_data_t d);
    inq_par_t p;
    for (int w = 0; w < `INQ_WIDTH / `INQ_PAR_WORD; w++)
      p[w] = ($countones(d[w*`INQ_PAR_WORD +: `INQ_PAR_WORD]) % 2) == 1;
    return p;
  endfunction

  function automatic inq_data_t rand_pkt();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic check_val(input string what, input logic [127:0] exp,
                           input logic [127:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic compare_outputs();
    check_val("count", 128'(mdl_q.size()), 128'(count));
    check_val("empty", 128'(mdl_q.size() == 0), 128'(empty));
    check_val("full", 128'(mdl_q.size() == `INQ_DEPTH), 128'(full));
    check_val("ovf", 128'(mdl_ovf), 128'(ovf));
    check_val("pkt_vld", 128'(exp_vld), 128'(pkt_vld));
    check_val("pkt", exp_pkt, pkt);
    check_val("pkt_par", 128'(word_par(exp_pkt)), 128'(pkt_par));
  endtask

  // one clock per call
  // drives after a falling edge and checks at the next one
  task automatic step(input logic e, input inq_data_t d, input logic q,
                      input logic f, input logic t);
    logic      push_ok;
    logic      pop_ok;
    inq_data_t pop_data;
    enq        = e;
    enq_data   = d;
    deq        = q;
    flush      = f;
    rst_tri_en = t;
    push_ok  = e && (mdl_q.size() < `INQ_DEPTH) && !f; // full drops even with a pop
    pop_ok   = q && (mdl_q.size() > 0) && !f;
    pop_data = '0;
    if (e && (mdl_q.size() == `INQ_DEPTH) && !f)
      mdl_ovf = 1'b1;
    if (pop_ok) begin
      pop_data = mdl_q.pop_front(); // gated read still uses the entry
      if (t)
        pop_data = '1;
    end
    if (push_ok)
      mdl_q.push_back(d);
    if (f)
      mdl_q.delete();
    @(posedge rclk);
    @(negedge rclk);
    exp_vld = stg_vld;              // second edge after deq
    if (stg_vld)
      exp_pkt = stg_pkt;
    stg_vld = pop_ok;
    stg_pkt = pop_data;
    compare_outputs();
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++)
      step(1'b0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic push_pkt(input inq_data_t d);
    step(1'b1, d, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic pop_pkt();
    step(1'b0, '0, 1'b1, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic check_reset_state();
    cur_test = "reset";
    idle(2);
    check_val("empty after reset", 128'(1), 128'(empty));
    pop_pkt();                      // ignored on an empty queue
    idle(3);
  endtask

  task automatic fifo_order();
    cur_test = "fifo_order";
    for (int i = 0; i < 5; i++)
      push_pkt(rand_pkt());
    for (int i = 0; i < 5; i++)
      pop_pkt();                    // back to back
    idle(3);
  endtask

  task automatic fill_and_wrap();
    cur_test = "fill_wrap";
    for (int i = 0; i < `INQ_DEPTH; i++)
      push_pkt(rand_pkt());
    check_val("full at 16", 128'(1), 128'(full));
    check_val("count at 16", 128'(`INQ_DEPTH), 128'(count));
    push_pkt(rand_pkt());           // dropped
    check_val("ovf on drop", 128'(1), 128'(ovf));
    for (int i = 0; i < 8; i++)
      pop_pkt();
    for (int i = 0; i < 8; i++)
      push_pkt(rand_pkt());         // rings wrap here
    for (int i = 0; i < `INQ_DEPTH; i++)
      pop_pkt();
    idle(3);
    check_val("empty after drain", 128'(1), 128'(empty));
  endtask

  task automatic push_pop_same_cycle();
    inq_data_t last;
    cur_test = "push_pop";
    for (int i = 0; i < 3; i++)
      push_pkt(rand_pkt());
    for (int i = 0; i < 4; i++)
      step(1'b1, rand_pkt(), 1'b1, 1'b0, 1'b0);
    check_val("count steady", 128'(3), 128'(count));
    for (int i = 0; i < 3; i++)
      pop_pkt();
    idle(2);
    last = rand_pkt();
    push_pkt(last);
    pop_pkt();                      // right behind the push
    idle(3);
    check_val("pop after push", last, pkt);
  endtask

  task automatic flush_queue();
    logic ovf_before;
    cur_test = "flush";
    ovf_before = mdl_ovf;
    for (int i = 0; i < 4; i++)
      push_pkt(rand_pkt());
    pop_pkt();                      // in flight across the flush
    step(1'b0, '0, 1'b0, 1'b1, 1'b0);
    check_val("count after flush", 128'(0), 128'(count));
    check_val("empty after flush", 128'(1), 128'(empty));
    check_val("ovf kept", 128'(ovf_before), 128'(ovf));
    idle(3);
    for (int i = 0; i < 3; i++)
      push_pkt(rand_pkt());
    for (int i = 0; i < 3; i++)
      pop_pkt();
    idle(3);
  endtask

  task automatic gate_reads();
    cur_test = "test_gate";
    for (int i = 0; i < 3; i++)
      push_pkt(rand_pkt());
    idle(2);
    step(1'b0, '0, 1'b1, 1'b0, 1'b1); // gated pop
    check_val("count after gated pop", 128'(2), 128'(count));
    idle(1);
    check_val("gated pkt", {`INQ_WIDTH{1'b1}}, pkt);
    for (int i = 0; i < 2; i++)
      pop_pkt();
    idle(3);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'h9620a94b));
    reset_l    = 1'b1;              // active high
    enq        = 1'b0;
    enq_data   = '0;
    deq        = 1'b0;
    flush      = 1'b0;
    rst_tri_en = 1'b0;
    mdl_ovf    = 1'b0;
    stg_vld    = 1'b0;
    stg_pkt    = '0;
    exp_vld    = 1'b0;
    exp_pkt    = '0;
    repeat (10) @(posedge rclk);
    @(negedge rclk);
    reset_l = 1'b0;
    check_reset_state();
    fifo_order();
    fill_and_wrap();
    push_pop_same_cycle();
    flush_queue();
    gate_reads();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
